//--- rtl/csr_stats_pkg.sv
// ====================
// CSR statistics package
// Sizes, index types, request payload and the constant
// feature header values of the CSR block
// ====================

package csr_stats_pkg;

    // ====================
    // CSR space
    // ====================

    // Number of 64 bit entries in CSR memory
    localparam int CSR_ENTRIES = 16;
    typedef logic [$clog2(CSR_ENTRIES)-1:0] csr_idx_t;

    // Host index is wider than the CSR space
    // so out of range requests can be seen
    localparam int CSR_REQ_IDX_W = 8;
    typedef logic [CSR_REQ_IDX_W-1:0] req_idx_t;

    // Transaction tag returned with each response
    localparam int TID_W = 9;
    typedef logic [TID_W-1:0] tid_t;

    // One CSR value
    typedef logic [63:0] csr_word_t;

    // Pending MMIO read requests
    localparam int REQ_QUEUE_DEPTH = 8;

    // Queue payload
    typedef struct packed {
        req_idx_t idx;
        tid_t     tid;
    } csr_req_t;

    // ====================
    // Statistics
    // ====================

    localparam int NUM_STATS = 4;
    // Small accumulator per event
    typedef logic [15:0] stat_cnt_t;
    typedef csr_idx_t [0:NUM_STATS-1] stat_idx_vec_t;
    typedef stat_cnt_t [0:NUM_STATS-1] stat_cnt_vec_t;

    // Cycles between flush attempts, a power of two
    localparam int FLUSH_PERIOD = 64;

    // ====================
    // Layout and constants
    // ====================

    localparam int DFH_IDX = 0;
    localparam int UID_L_IDX = 1;
    localparam int UID_H_IDX = 2;
    // Counter i lives at STAT_BASE_IDX + i
    localparam int STAT_BASE_IDX = 4;

    // Entries written by the init sequencer after reset
    localparam int NUM_INIT_ENTRIES = 3;

    // Type BBB in [63:60], end of list in bit 40, feature ID 1
    localparam csr_word_t FEATURE_DFH = 64'h2000_0100_0000_0001;
    localparam logic [127:0] FEATURE_UID = 128'h7e41b2d9_0c63_4f8a_95e2_1d07c4b36a58;

endpackage

//--- rtl/csr_mem_if.sv
`timescale 1ns/1ps

// ====================
// CSR memory port bundle
// One read port answered by a valid pulse and one
// 64 bit write port, both gated by a ready flag
// ====================

interface csr_mem_if
    import csr_stats_pkg::*;
();

    // Read request and entry index
    logic      rd_en;
    csr_idx_t  rd_idx;
    // Memory can accept a read
    logic      rd_rdy;
    // Read data, qualified by a one cycle pulse
    csr_word_t rd_val;
    logic      rd_val_valid;

    // Write request, entry index and value
    logic      wr_en;
    csr_idx_t  wr_idx;
    csr_word_t wr_val;
    // Low while the upper half of a write goes in
    logic      wr_rdy;

    // Requesting side
    modport client
    (
        output rd_en, rd_idx, wr_en, wr_idx, wr_val,
        input  rd_rdy, rd_val, rd_val_valid, wr_rdy
    );

    // Storage side
    modport memory
    (
        input  rd_en, rd_idx, wr_en, wr_idx, wr_val,
        output rd_rdy, rd_val, rd_val_valid, wr_rdy
    );

endinterface

//--- rtl/csr_rd_memory.sv
`timescale 1ns/1ps

// ====================
// CSR backing memory
// A single 32 bit RAM double pumped to hold 64 bit entries
// Writes take two cycles, reads answer after three
// Feature header and UID are written after reset
// ====================

module csr_rd_memory
    import csr_stats_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    csr_mem_if.memory mem
);

    // Power-up contents of zero for counters and unused entries
    logic [31:0] ram [0:2*CSR_ENTRIES-1] = '{default: 32'h0};

    // RAM address is entry index with the half select below it
    logic                      wen;
    logic [$bits(csr_idx_t):0] waddr;
    logic [31:0]               wdata;
    logic [$bits(csr_idx_t):0] raddr;
    logic [31:0]               ram_q;
    logic [31:0]               rdata;

    // Write side state
    logic        initialized;
    logic        wr_upper;
    csr_idx_t    wr_idx_q;
    logic [31:0] wr_hi_q;

    // Init vectors, element 0 is the next one to write
    logic [2*NUM_INIT_ENTRIES-1:0][31:0] init_val;
    csr_idx_t [NUM_INIT_ENTRIES-1:0]     init_idx;
    // One bit per entry still to be written
    logic [NUM_INIT_ENTRIES-1:0]         init_left;

    // Read side state
    logic        rd_upper;
    csr_idx_t    rd_idx_q;
    logic        rd_busy;
    logic [2:0]  rd_pipe;
    logic [31:0] rd_val_low;

    // Registered read plus one output stage
    always_ff @(posedge clk)
    begin
        if (wen)
        begin
            ram[waddr] <= wdata;
        end
        ram_q <= ram[raddr];
        rdata <= ram_q;
    end

    // ====================
    // Writes and init
    // ====================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            initialized <= 1'b0;
            wr_upper <= 1'b0;
            init_left <= '1;
            // DFH first, then UID low and high words
            init_val <= {FEATURE_UID, FEATURE_DFH};
            init_idx <= {csr_idx_t'(UID_H_IDX), csr_idx_t'(UID_L_IDX), csr_idx_t'(DFH_IDX)};
        end
        else if (!initialized)
        begin
            // One 32 bit init word per cycle
            wr_upper <= !wr_upper;
            init_val <= init_val >> 32;
            if (wr_upper)
            begin
                // Entry complete, move to the next index
                init_idx <= init_idx >> $bits(csr_idx_t);
                init_left <= init_left >> 1;
                initialized <= ((init_left >> 1) == '0);
            end
        end
        else
        begin
            // Upper half goes in the cycle after an accepted write
            wr_upper <= mem.wr_en;
        end
    end

    // Upper half and index held for the second cycle
    always_ff @(posedge clk)
    begin
        if (mem.wr_en)
        begin
            wr_idx_q <= mem.wr_idx;
            wr_hi_q <= mem.wr_val[63:32];
        end
    end

    assign mem.wr_rdy = initialized && !wr_upper;

    // Write port source select
    always_comb
    begin
        if (!initialized)
        begin
            wen = 1'b1;
            waddr = {init_idx[0], wr_upper};
            wdata = init_val[0];
        end
        else if (wr_upper)
        begin
            wen = 1'b1;
            waddr = {wr_idx_q, 1'b1};
            wdata = wr_hi_q;
        end
        else
        begin
            // Low half written in the accepting cycle
            wen = mem.wr_en;
            waddr = {mem.wr_idx, 1'b0};
            wdata = mem.wr_val[31:0];
        end
    end

    // ====================
    // Reads
    // ====================

    // Low half from the request, high half a cycle later
    assign raddr = rd_upper ? {rd_idx_q, 1'b1} : {mem.rd_idx, 1'b0};

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_upper <= 1'b0;
            rd_busy <= 1'b0;
            rd_pipe <= '0;
        end
        else
        begin
            rd_upper <= mem.rd_en;
            // Busy from acceptance until the answer leaves
            rd_busy <= rd_busy ^ (mem.rd_en | rd_pipe[2]);
            rd_pipe <= {rd_pipe[1:0], mem.rd_en};
        end
    end

    always_ff @(posedge clk)
    begin
        if (mem.rd_en)
        begin
            rd_idx_q <= mem.rd_idx;
        end
        // Low half arrives one cycle ahead of the high half
        if (rd_pipe[1])
        begin
            rd_val_low <= rdata;
        end
    end

    assign mem.rd_rdy = initialized && !rd_busy;
    assign mem.rd_val_valid = rd_pipe[2];
    assign mem.rd_val = {rdata, rd_val_low};

endmodule

//--- rtl/csr_event_counters.sv
`timescale 1ns/1ps

// ====================
// Event counters
// Small accumulators per event, handed to the CSR
// manager as a vector once every flush period
// ====================

module csr_event_counters
    import csr_stats_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic [NUM_STATS-1:0] events,
    input  logic                 stat_upd_rdy,
    output logic                 stat_upd_en,
    output stat_idx_vec_t        stat_upd_idx,
    output stat_cnt_vec_t        stat_upd_cnt
);

    logic [$clog2(FLUSH_PERIOD)-1:0] period_cnt;
    logic                            period_done;
    logic                            flush;

    // ====================
    // Flush timing
    // ====================

    // All ones marks the end of a period
    assign period_done = (period_cnt == '1);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            period_cnt <= '0;
            flush <= 1'b0;
        end
        else
        begin
            // Single pulse, only when the manager was ready
            flush <= period_done && stat_upd_rdy && !flush;
            if (flush)
            begin
                period_cnt <= '0;
            end
            else if (!period_done)
            begin
                // Hold at the end until the manager is free
                period_cnt <= period_cnt + 1'b1;
            end
        end
    end

    assign stat_upd_en = flush;

    // ====================
    // Accumulators
    // ====================

    for (genvar i = 0; i < NUM_STATS; i++)
    begin : g_stat
        logic      ev_q;
        stat_cnt_t acc;

        always_ff @(posedge clk)
        begin
            if (reset)
            begin
                ev_q <= 1'b0;
                acc <= '0;
            end
            else
            begin
                ev_q <= events[i];
                // Restart on flush but keep the event registered now
                acc <= (flush ? stat_cnt_t'(0) : acc) + stat_cnt_t'(ev_q);
            end
        end

        assign stat_upd_cnt[i] = acc;
        // Fixed counter entry for this event
        assign stat_upd_idx[i] = csr_idx_t'(STAT_BASE_IDX + i);
    end

endmodule

//--- rtl/csr_req_fifo.sv
`timescale 1ns/1ps

// ====================
// MMIO read request queue
// Circular buffer of tag and index with a registered head
// ====================

module csr_req_fifo
    import csr_stats_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     enq_valid,
    output logic     enq_ready,
    input  req_idx_t enq_idx,
    input  tid_t     enq_tid,
    output logic     deq_valid,
    input  logic     deq_en,
    output req_idx_t deq_idx,
    output tid_t     deq_tid
);

    csr_req_t                           buffer [0:REQ_QUEUE_DEPTH-1];
    logic [$clog2(REQ_QUEUE_DEPTH)-1:0] wr_ptr;
    logic [$clog2(REQ_QUEUE_DEPTH)-1:0] rd_ptr;
    // Entries held in total, head included
    logic [$clog2(REQ_QUEUE_DEPTH):0]   count;
    csr_req_t                           enq_req;
    csr_req_t                           head;
    logic                               push;
    logic                               head_load;
    logic                               body_empty;
    logic                               body_push;
    logic                               body_pop;

    assign enq_req = '{idx: enq_idx, tid: enq_tid};

    // Depth is a power of two, so the top count bit means full
    assign enq_ready = !count[$clog2(REQ_QUEUE_DEPTH)];
    assign push = enq_valid && enq_ready;

    // Head register empty or leaving this cycle
    assign head_load = !deq_valid || deq_en;
    // Body never fills since the head takes one entry
    assign body_empty = (wr_ptr == rd_ptr);
    // An empty body is bypassed straight into the head
    assign body_push = push && !(head_load && body_empty);
    assign body_pop = head_load && !body_empty;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            deq_valid <= 1'b0;
        end
        else
        begin
            if (body_push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (body_pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !deq_en)
            begin
                count <= count + 1'b1;
            end
            else if (!push && deq_en)
            begin
                count <= count - 1'b1;
            end
            if (head_load)
            begin
                deq_valid <= !body_empty || push;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (body_push)
        begin
            buffer[wr_ptr] <= enq_req;
        end
        if (head_load)
        begin
            head <= body_empty ? enq_req : buffer[rd_ptr];
        end
    end

    assign deq_idx = head.idx;
    assign deq_tid = head.tid;

endmodule

//--- rtl/csr_manager.sv
`timescale 1ns/1ps

// ====================
// CSR manager
// Serves queued MMIO reads from CSR memory and folds
// statistics accumulators into 64 bit counters
// ====================

module csr_manager
    import csr_stats_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          deq_valid,
    output logic          deq_en,
    input  req_idx_t      deq_idx,
    input  tid_t          deq_tid,
    output logic          rsp_valid,
    input  logic          rsp_ready,
    output tid_t          rsp_tid,
    output csr_word_t     rsp_data,
    output logic          stat_upd_rdy,
    input  logic          stat_upd_en,
    input  stat_idx_vec_t stat_upd_idx,
    input  stat_cnt_vec_t stat_upd_cnt,
    csr_mem_if.client     mem
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ,
        ST_ADD_LO,
        ST_ADD_HI,
        ST_WRITE
    } fold_state_t;

    logic            out_of_range;
    logic            mmio_start;
    logic            mmio_active;
    logic            stat_rd;
    fold_state_t     state;
    // Entries still to fold, one bit each
    logic [NUM_STATS-1:0] fold_left;
    stat_idx_vec_t   fold_idx;
    stat_cnt_vec_t   fold_cnt;
    csr_word_t       fold_sum;
    logic            fold_carry;
    logic [31:0]     fold_hi;

    // ====================
    // MMIO reads
    // ====================

    assign out_of_range = (deq_idx >= req_idx_t'(CSR_ENTRIES));

    // One read at a time and only with the response register free
    assign mmio_start = deq_valid && !out_of_range && !rsp_valid && !mmio_active && mem.rd_rdy;
    // Out of range heads are dropped without a response
    assign deq_en = mmio_start || (deq_valid && out_of_range);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mmio_active <= 1'b0;
            rsp_valid <= 1'b0;
        end
        else
        begin
            if (mmio_start)
            begin
                mmio_active <= 1'b1;
            end
            if (mmio_active && mem.rd_val_valid)
            begin
                mmio_active <= 1'b0;
                rsp_valid <= 1'b1;
            end
            if (rsp_valid && rsp_ready)
            begin
                rsp_valid <= 1'b0;
            end
        end
    end

    // Tag and data stay put while a response waits
    always_ff @(posedge clk)
    begin
        if (mmio_start)
        begin
            rsp_tid <= deq_tid;
        end
        if (mmio_active && mem.rd_val_valid)
        begin
            rsp_data <= mem.rd_val;
        end
    end

    // ====================
    // Statistics fold
    // ====================

    // MMIO reads win the read port
    assign stat_rd = (state == ST_READ) && mem.rd_rdy && !mmio_start;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= ST_IDLE;
            stat_upd_rdy <= 1'b1;
            fold_left <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (stat_upd_en)
                    begin
                        state <= ST_READ;
                        stat_upd_rdy <= 1'b0;
                        fold_left <= '1;
                    end
                end
                ST_READ:
                begin
                    if (stat_rd)
                    begin
                        state <= ST_ADD_LO;
                    end
                end
                ST_ADD_LO:
                begin
                    // Wait for the counter value
                    if (mem.rd_val_valid)
                    begin
                        state <= ST_ADD_HI;
                    end
                end
                ST_ADD_HI:
                begin
                    state <= ST_WRITE;
                end
                ST_WRITE:
                begin
                    if (mem.wr_en)
                    begin
                        fold_left <= fold_left >> 1;
                        if ((fold_left >> 1) == '0)
                        begin
                            state <= ST_IDLE;
                            stat_upd_rdy <= 1'b1;
                        end
                        else
                        begin
                            state <= ST_READ;
                        end
                    end
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Fold datapath
    always_ff @(posedge clk)
    begin
        case (state)
            ST_IDLE:
            begin
                if (stat_upd_en)
                begin
                    fold_idx <= stat_upd_idx;
                    fold_cnt <= stat_upd_cnt;
                end
            end
            ST_ADD_LO:
            begin
                if (mem.rd_val_valid)
                begin
                    // Low half plus accumulator, carry kept aside
                    {fold_carry, fold_sum[31:0]} <=
                        {1'b0, mem.rd_val[31:0]} + 33'(fold_cnt[0]);
                    fold_hi <= mem.rd_val[63:32];
                end
            end
            ST_ADD_HI:
            begin
                fold_sum[63:32] <= fold_hi + 32'(fold_carry);
            end
            ST_WRITE:
            begin
                if (mem.wr_en)
                begin
                    // Element 0 is the MSB slice, shift the next one in
                    fold_idx <= fold_idx << $bits(csr_idx_t);
                    fold_cnt <= fold_cnt << $bits(stat_cnt_t);
                end
            end
            default:
            begin
            end
        endcase
    end

    // ====================
    // Memory port
    // ====================

    assign mem.rd_en = mmio_start || stat_rd;
    // Index already checked against the CSR range
    assign mem.rd_idx = mmio_start ? csr_idx_t'(deq_idx) : fold_idx[0];
    assign mem.wr_en = (state == ST_WRITE) && mem.wr_rdy;
    assign mem.wr_idx = fold_idx[0];
    assign mem.wr_val = fold_sum;

endmodule

//--- rtl/csr_stats_top.sv
`timescale 1ns/1ps

// ====================
// CSR statistics block
// Request queue, CSR manager, event counters
// and CSR memory on plain valid/ready ports
// ====================

module csr_stats_top
    import csr_stats_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 req_valid,
    output logic                 req_ready,
    input  req_idx_t             req_idx,
    input  tid_t                 req_tid,
    output logic                 rsp_valid,
    input  logic                 rsp_ready,
    output tid_t                 rsp_tid,
    output csr_word_t            rsp_data,
    input  logic [NUM_STATS-1:0] events
);

    // Queue head toward the manager
    logic          deq_valid;
    logic          deq_en;
    req_idx_t      deq_idx;
    tid_t          deq_tid;

    // Statistics handoff
    logic          stat_upd_rdy;
    logic          stat_upd_en;
    stat_idx_vec_t stat_upd_idx;
    stat_cnt_vec_t stat_upd_cnt;

    csr_mem_if mem_bus ();

    csr_req_fifo i_req_fifo
    (
        .clk,
        .reset,
        .enq_valid (req_valid),
        .enq_ready (req_ready),
        .enq_idx   (req_idx),
        .enq_tid   (req_tid),
        .deq_valid,
        .deq_en,
        .deq_idx,
        .deq_tid
    );

    csr_manager i_manager
    (
        .clk,
        .reset,
        .deq_valid,
        .deq_en,
        .deq_idx,
        .deq_tid,
        .rsp_valid,
        .rsp_ready,
        .rsp_tid,
        .rsp_data,
        .stat_upd_rdy,
        .stat_upd_en,
        .stat_upd_idx,
        .stat_upd_cnt,
        .mem (mem_bus)
    );

    csr_event_counters i_event_counters
    (
        .clk,
        .reset,
        .events,
        .stat_upd_rdy,
        .stat_upd_en,
        .stat_upd_idx,
        .stat_upd_cnt
    );

    csr_rd_memory i_rd_memory
    (
        .clk,
        .reset,
        .mem (mem_bus)
    );

endmodule

//--- bench/csr_stats_props.sv
`timescale 1ns/1ps

// ====================
// Response channel properties
// Bound onto the CSR statistics top level
// ====================

module csr_stats_props
    import csr_stats_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input logic      rsp_valid,
    input logic      rsp_ready,
    input tid_t      rsp_tid,
    input csr_word_t rsp_data
);

    // No response right out of reset
    a_reset_idle: assert property (@(posedge clk) reset |=> !rsp_valid)
        else $error("rsp_valid high after a reset cycle");

    // Stalled response keeps valid, tag and data
    a_rsp_hold: assert property (@(posedge clk) disable iff (reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_tid) && $stable(rsp_data))
        else $error("Stalled response changed before acceptance");

endmodule

bind csr_stats_top csr_stats_props i_props
(
    .clk       (clk),
    .reset     (reset),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_tid   (rsp_tid),
    .rsp_data  (rsp_data)
);

//--- bench/csr_stats_tb.sv
`timescale 1ns/1ps

// ====================
// CSR statistics testbench
// Directed reads of the feature header, UID and counters,
// event folding, back-pressure and out of range requests
// ====================

module csr_stats_tb
    import csr_stats_pkg::*;
();

    // Upper bound of pulses per event in one burst
    localparam int MAX_PULSES = 40;
    // Two flush periods plus fold time, with margin
    localparam int SETTLE_CYCLES = 3 * FLUSH_PERIOD + 40;
    // Cycles allowed for one response to show up
    localparam int RSP_WAIT_LIMIT = 100;
    // Generous cost of one read round trip
    localparam int READ_CYCLES = 20;
    // Two bursts with settling, about forty reads, reset and init
    localparam int TIMEOUT_CYCLES =
        2 * (2 * MAX_PULSES + SETTLE_CYCLES) + 40 * READ_CYCLES + 100;

    logic                 clk;
    logic                 reset;
    logic                 req_valid;
    logic                 req_ready;
    req_idx_t             req_idx;
    tid_t                 req_tid;
    logic                 rsp_valid;
    logic                 rsp_ready;
    tid_t                 rsp_tid;
    csr_word_t            rsp_data;
    logic [NUM_STATS-1:0] events;

    int errors = 0;
    int checks = 0;
    int cycle_cnt = 0;

    // Expected CSR contents
    csr_word_t exp_mem [0:CSR_ENTRIES-1];

    csr_stats_top i_dut
    (
        .clk,
        .reset,
        .req_valid,
        .req_ready,
        .req_idx,
        .req_tid,
        .rsp_valid,
        .rsp_ready,
        .rsp_tid,
        .rsp_data,
        .events
    );

    always #10 clk = ~clk;

    // Watchdog
    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // ====================
    // Compare tasks
    // ====================

    task automatic check_word(input string name, input csr_word_t exp, input csr_word_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_tid(input string name, input tid_t exp, input tid_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // ====================
    // Bus tasks
    // ====================

    // Hold the request until req_ready is seen at a rising edge
    task automatic send_req(input req_idx_t idx, input tid_t tid);
        @(posedge clk);
        req_valid <= 1'b1;
        req_idx <= idx;
        req_tid <= tid;
        @(negedge clk);
        while (!req_ready)
        begin
            @(negedge clk);
        end
        // Accepted at this edge
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    // Sampled mid cycle, taken at the following edge
    task automatic recv_rsp(input string name, output logic got, output tid_t tid,
                            output csr_word_t data);
        int waited;
        waited = 0;
        got = 1'b0;
        while (!got && waited < RSP_WAIT_LIMIT)
        begin
            @(negedge clk);
            if (rsp_valid && rsp_ready)
            begin
                got = 1'b1;
                tid = rsp_tid;
                data = rsp_data;
            end
            waited++;
        end
        if (got)
        begin
            @(posedge clk);
        end
        else
        begin
            errors++;
            $display("%s: no response within %0d cycles", name, RSP_WAIT_LIMIT);
        end
    endtask

    task automatic read_check(input string name, input int idx, input tid_t tid);
        logic      got;
        tid_t      act_tid;
        csr_word_t act_data;
        send_req(req_idx_t'(idx), tid);
        recv_rsp(name, got, act_tid, act_data);
        if (got)
        begin
            check_tid(name, tid, act_tid);
            check_word(name, exp_mem[idx], act_data);
        end
    endtask

    // ====================
    // Tests
    // ====================

    task automatic test_header_reads();
        read_check("dfh", DFH_IDX, 9'h101);
        read_check("uid_low", UID_L_IDX, 9'h0a5);
        read_check("uid_high", UID_H_IDX, 9'h1ff);
    endtask

    task automatic test_unused_reads();
        read_check("unused_3", 3, 9'h033);
        read_check("unused_15", CSR_ENTRIES - 1, 9'h0f0);
    endtask

    // Pulses every other cycle, then wait for the fold
    task automatic test_event_counts(input string name);
        int cnt [0:NUM_STATS-1];
        int max_cnt;
        int c;
        int i;
        logic [NUM_STATS-1:0] ev;
        max_cnt = 0;
        for (i = 0; i < NUM_STATS; i++)
        begin
            cnt[i] = $urandom_range(1, MAX_PULSES);
            if (cnt[i] > max_cnt)
            begin
                max_cnt = cnt[i];
            end
        end
        for (c = 0; c < max_cnt; c++)
        begin
            for (i = 0; i < NUM_STATS; i++)
            begin
                ev[i] = (c < cnt[i]);
            end
            @(posedge clk);
            events <= ev;
            @(posedge clk);
            events <= '0;
        end
        repeat (SETTLE_CYCLES) @(posedge clk);
        // Counters hold the running total
        for (i = 0; i < NUM_STATS; i++)
        begin
            exp_mem[STAT_BASE_IDX + i] += csr_word_t'(cnt[i]);
            read_check($sformatf("%s_event%0d", name, i), STAT_BASE_IDX + i,
                       tid_t'($urandom_range(0, 511)));
        end
    endtask

    // Fill the queue under back-pressure, then drain in order
    task automatic test_backpressure();
        tid_t      exp_tid_q [$];
        int        exp_idx_q [$];
        int        n;
        int        k;
        int        idx;
        logic      full;
        logic      got;
        tid_t      tid;
        tid_t      act_tid;
        csr_word_t act_data;
        n = 0;
        full = 1'b0;
        @(posedge clk);
        rsp_ready <= 1'b0;
        while (!full && n < 2 * REQ_QUEUE_DEPTH)
        begin
            idx = $urandom_range(0, CSR_ENTRIES - 1);
            tid = tid_t'($urandom_range(0, 511));
            @(posedge clk);
            req_valid <= 1'b1;
            req_idx <= req_idx_t'(idx);
            req_tid <= tid;
            @(negedge clk);
            if (req_ready)
            begin
                exp_tid_q.push_back(tid);
                exp_idx_q.push_back(idx);
                n++;
            end
            else
            begin
                full = 1'b1;
            end
        end
        @(posedge clk);
        req_valid <= 1'b0;
        // One response held plus a full queue
        if (!full)
        begin
            errors++;
            $display("backpressure: req_ready stayed high for %0d requests", n);
        end
        else if (n != REQ_QUEUE_DEPTH + 1)
        begin
            errors++;
            $display("backpressure: req_ready fell after %0d requests instead of %0d",
                     n, REQ_QUEUE_DEPTH + 1);
        end
        rsp_ready <= 1'b1;
        for (k = 0; k < n; k++)
        begin
            recv_rsp("backpressure", got, act_tid, act_data);
            if (got)
            begin
                check_tid($sformatf("backpressure_%0d", k), exp_tid_q[k], act_tid);
                check_word($sformatf("backpressure_%0d", k), exp_mem[exp_idx_q[k]],
                           act_data);
            end
        end
    endtask

    // Out of range request is dropped, the next one answers
    task automatic test_out_of_range();
        logic      got;
        tid_t      act_tid;
        csr_word_t act_data;
        send_req(req_idx_t'(CSR_ENTRIES), 9'h0bd);
        send_req(req_idx_t'(UID_H_IDX), 9'h0c4);
        recv_rsp("out_of_range", got, act_tid, act_data);
        if (got)
        begin
            check_tid("out_of_range", 9'h0c4, act_tid);
            check_word("out_of_range", exp_mem[UID_H_IDX], act_data);
        end
        // Nothing else may follow
        repeat (20)
        begin
            @(negedge clk);
            if (rsp_valid)
            begin
                errors++;
                $display("out_of_range: unexpected extra response with tag %h", rsp_tid);
            end
        end
    endtask

    // ====================
    // Main sequence
    // ====================

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        req_valid = 1'b0;
        req_idx = '0;
        req_tid = '0;
        rsp_ready = 1'b1;
        events = '0;
        void'($urandom(81));
        for (int e = 0; e < CSR_ENTRIES; e++)
        begin
            exp_mem[e] = '0;
        end
        exp_mem[DFH_IDX] = FEATURE_DFH;
        exp_mem[UID_L_IDX] = FEATURE_UID[63:0];
        exp_mem[UID_H_IDX] = FEATURE_UID[127:64];

        repeat (4) @(posedge clk);
        reset <= 1'b0;

        test_header_reads();
        test_unused_reads();
        test_event_counts("burst1");
        test_event_counts("burst2");
        test_backpressure();
        test_out_of_range();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("TESTS PASSED");
        end
        else
        begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- project.f
rtl/csr_stats_pkg.sv
rtl/csr_mem_if.sv
rtl/csr_rd_memory.sv
rtl/csr_event_counters.sv
rtl/csr_req_fifo.sv
rtl/csr_manager.sv
rtl/csr_stats_top.sv
bench/csr_stats_props.sv
bench/csr_stats_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the CSR statistics testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module csr_stats_tb -o csr_stats_sim &&
./obj_dir/csr_stats_sim | tee /dev/stderr | grep -x "TESTS PASSED" > /dev/null &&
echo "Simulation result: pass" ||
{ echo "Simulation result: fail"; exit 1; }
